/* source/udp_field_pkg.sv */
// UDP header field types and the 64-bit payload word layout; byte 0 sits in bits 7:0
package udp_field_pkg;

    // Payload stream geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = 8;

    // IPv4 address in network order, first octet in the top byte
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // One payload beat
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Byte enables, one per payload byte
    typedef logic [KEEP_WIDTH-1:0] keep_t;

endpackage

/* source/echo_cfg_pkg.sv */
// Echo application constants; TTL and local address are consumed by the surrounding UDP stack
package echo_cfg_pkg;

    import udp_field_pkg::*;

    // Only this destination port is answered
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Local address, 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // TTL of outgoing replies
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Payload FIFO holds 2**FIFO_ADDR_WIDTH words
    localparam int FIFO_ADDR_WIDTH = 10;

    // Width of the LED output
    localparam int LED_WIDTH = 4;

endpackage

/* source/axis_payload_if.sv */
// Payload beat stream; a beat moves on a clock edge with valid and ready both high
`timescale 1ns/1ps

interface axis_payload_if;

    import udp_field_pkg::*;

    data_word_t data;
    keep_t      keep;
    logic       valid;
    logic       ready;
    logic       last;
    logic       user;

    // Producer side
    modport source (output data, keep, valid, last, user, input ready);

    // Consumer side
    modport sink (input data, keep, valid, last, user, output ready);

    // Passive observer
    modport monitor (input data, keep, valid, ready, last, user);

endinterface

/* source/echo_port_filter.sv */
// Every rx header must be followed by at least one payload beat ending in last
`timescale 1ns/1ps

module echo_port_filter (
    input  logic                      clk,
    input  logic                      rst,

    // Received UDP header
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_field_pkg::ip_addr_t   rx_src_ip,
    input  udp_field_pkg::udp_port_t  rx_src_port,
    input  udp_field_pkg::udp_port_t  rx_dest_port,
    input  udp_field_pkg::udp_len_t   rx_udp_length,

    // Reply UDP header
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_field_pkg::ip_addr_t   tx_dest_ip,
    output udp_field_pkg::udp_port_t  tx_src_port,
    output udp_field_pkg::udp_port_t  tx_dest_port,
    output udp_field_pkg::udp_len_t   tx_udp_length,

    // Received payload
    input  udp_field_pkg::data_word_t rx_data,
    input  udp_field_pkg::keep_t      rx_keep,
    input  logic                      rx_valid,
    output logic                      rx_ready,
    input  logic                      rx_last,
    input  logic                      rx_user,

    // Payload towards the FIFO
    axis_payload_if.source            fifo_in
);

    import echo_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        KEEP,
        DROP
    } filter_state_t;

    filter_state_t state_q;
    filter_state_t state_d;
    logic          port_match;
    logic          hdr_fire;
    logic          beat_fire;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Reply header goes out in the same cycle as the request header
    assign tx_hdr_valid  = rx_hdr_valid && port_match && (state_q == IDLE);
    assign tx_dest_ip    = rx_src_ip;
    assign tx_src_port   = rx_dest_port;
    assign tx_dest_port  = rx_src_port;
    assign tx_udp_length = rx_udp_length;

    // Payload is only presented to the FIFO for kept frames
    assign fifo_in.data  = rx_data;
    assign fifo_in.keep  = rx_keep;
    assign fifo_in.last  = rx_last;
    assign fifo_in.user  = rx_user;
    assign fifo_in.valid = rx_valid && (state_q == KEEP);

    always_comb begin
        rx_hdr_ready = 1'b0;
        rx_ready     = 1'b0;
        case (state_q)
            IDLE: begin
                // Matching headers wait for the reply side, others are swallowed
                rx_hdr_ready = port_match ? tx_hdr_ready : 1'b1;
            end
            KEEP: begin
                rx_ready = fifo_in.ready;
            end
            DROP: begin
                rx_ready = 1'b1;
            end
            default: begin
                rx_ready = 1'b0;
            end
        endcase
    end

    assign hdr_fire  = rx_hdr_valid && rx_hdr_ready;
    assign beat_fire = rx_valid && rx_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (hdr_fire) begin
                    state_d = port_match ? KEEP : DROP;
                end
            end
            KEEP, DROP: begin
                if (beat_fire && rx_last) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* source/payload_fifo.sv */
// Cut-through word FIFO with asynchronous read; ADDR_WIDTH must be at least 1
`timescale 1ns/1ps

module payload_fifo #(
    parameter int ADDR_WIDTH = echo_cfg_pkg::FIFO_ADDR_WIDTH
) (
    input  logic           clk,
    input  logic           rst,
    axis_payload_if.sink   in,
    axis_payload_if.source out
);

    import udp_field_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // Storage, one entry per beat
    data_word_t data_mem [DEPTH];
    keep_t      keep_mem [DEPTH];
    logic       last_mem [DEPTH];
    logic       user_mem [DEPTH];

    // Extra top bit tells full from empty when the addresses meet
    logic [ADDR_WIDTH:0]   wr_ptr_q;
    logic [ADDR_WIDTH:0]   rd_ptr_q;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  full;
    logic                  empty;
    logic                  wr_en;
    logic                  rd_en;

    assign wr_addr = wr_ptr_q[ADDR_WIDTH-1:0];
    assign rd_addr = rd_ptr_q[ADDR_WIDTH-1:0];

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[ADDR_WIDTH] != rd_ptr_q[ADDR_WIDTH])
                && (wr_addr == rd_addr);

    assign in.ready = !full;
    assign wr_en    = in.valid && !full;
    assign rd_en    = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr] <= in.data;
            keep_mem[wr_addr] <= in.keep;
            last_mem[wr_addr] <= in.last;
            user_mem[wr_addr] <= in.user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Head entry stays on the outputs until it is taken
    assign out.valid = !empty;
    assign out.data  = data_mem[rd_addr];
    assign out.keep  = keep_mem[rd_addr];
    assign out.last  = last_mem[rd_addr];
    assign out.user  = user_mem[rd_addr];

endmodule

/* source/led_capture.sv */
// Shows the low bits of byte 0 of the latest outgoing frame; needs last on every frame
`timescale 1ns/1ps

module led_capture (
    input  logic                                 clk,
    input  logic                                 rst,
    axis_payload_if.monitor                      mon,
    output logic [echo_cfg_pkg::LED_WIDTH-1:0]   led
);

    import echo_cfg_pkg::*;

    logic first_beat_q;
    logic beat_fire;

    assign beat_fire = mon.valid && mon.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat_q <= 1'b1;
            led          <= '0;
        end else if (beat_fire) begin
            if (first_beat_q) begin
                led <= mon.data[LED_WIDTH-1:0];
            end
            // Next beat opens a new frame only after last
            first_beat_q <= mon.last;
        end
    end

endmodule

/* source/udp_echo_top.sv */
// UDP echo at the stack boundary; TTL, source IP and checksum are added by the stack
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                                clk,
    input  logic                                rst,

    // Received UDP header
    input  logic                                rx_hdr_valid,
    output logic                                rx_hdr_ready,
    input  udp_field_pkg::ip_addr_t             rx_src_ip,
    input  udp_field_pkg::udp_port_t            rx_src_port,
    input  udp_field_pkg::udp_port_t            rx_dest_port,
    input  udp_field_pkg::udp_len_t             rx_udp_length,

    // Received payload
    input  udp_field_pkg::data_word_t           rx_data,
    input  udp_field_pkg::keep_t                rx_keep,
    input  logic                                rx_valid,
    output logic                                rx_ready,
    input  logic                                rx_last,
    input  logic                                rx_user,

    // Reply UDP header
    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_field_pkg::ip_addr_t             tx_dest_ip,
    output udp_field_pkg::udp_port_t            tx_src_port,
    output udp_field_pkg::udp_port_t            tx_dest_port,
    output udp_field_pkg::udp_len_t             tx_udp_length,

    // Reply payload
    output udp_field_pkg::data_word_t           tx_data,
    output udp_field_pkg::keep_t                tx_keep,
    output logic                                tx_valid,
    input  logic                                tx_ready,
    output logic                                tx_last,
    output logic                                tx_user,

    output logic [echo_cfg_pkg::LED_WIDTH-1:0]  led
);

    // Filter to FIFO, and FIFO to the reply payload ports
    axis_payload_if fifo_in ();
    axis_payload_if fifo_out ();

    echo_port_filter filter_i (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_src_ip     (rx_src_ip),
        .rx_src_port   (rx_src_port),
        .rx_dest_port  (rx_dest_port),
        .rx_udp_length (rx_udp_length),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_dest_ip    (tx_dest_ip),
        .tx_src_port   (tx_src_port),
        .tx_dest_port  (tx_dest_port),
        .tx_udp_length (tx_udp_length),
        .rx_data       (rx_data),
        .rx_keep       (rx_keep),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .rx_last       (rx_last),
        .rx_user       (rx_user),
        .fifo_in       (fifo_in)
    );

    payload_fifo #(
        .ADDR_WIDTH (echo_cfg_pkg::FIFO_ADDR_WIDTH)
    ) fifo_i (
        .clk (clk),
        .rst (rst),
        .in  (fifo_in),
        .out (fifo_out)
    );

    led_capture led_i (
        .clk (clk),
        .rst (rst),
        .mon (fifo_out),
        .led (led)
    );

    assign tx_data        = fifo_out.data;
    assign tx_keep        = fifo_out.keep;
    assign tx_valid       = fifo_out.valid;
    assign tx_last        = fifo_out.last;
    assign tx_user        = fifo_out.user;
    assign fifo_out.ready = tx_ready;

endmodule

/* dv/udp_echo_chk.sv */
// Reply side rules of udp_echo_top, sampled on the rising edge of clk
`timescale 1ns/1ps

module udp_echo_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      tx_valid,
    input logic                      tx_ready,
    input udp_field_pkg::data_word_t tx_data,
    input udp_field_pkg::keep_t      tx_keep,
    input logic                      tx_last,
    input logic                      tx_hdr_valid,
    input udp_field_pkg::udp_port_t  tx_src_port
);

    import echo_cfg_pkg::*;

    // A stalled beat stays on the bus unchanged
    tx_hold_a: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=>
            (tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last)))
        else $error("tx beat dropped or changed while tx_ready was low");

    // Replies always come from the echo port
    hdr_port_a: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> (tx_src_port == ECHO_PORT))
        else $error("reply header with a source port other than the echo port");

    reset_idle_a: assert property (@(posedge clk)
        rst |=> (!tx_valid && !tx_hdr_valid))
        else $error("reply valid high in the cycle after reset");

endmodule

/* dv/udp_echo_tb.sv */
// Inputs change on the falling edge and outputs are read 1 ns later; the FIFO is never filled
`timescale 1ns/1ps

module udp_echo_tb;

    import udp_field_pkg::*;
    import echo_cfg_pkg::*;

    localparam int SEED  = 42690;
    localparam int LIMIT = 4000;
    localparam int QUIET = 8;

    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
        udp_len_t  udp_length;
    } hdr_t;

    typedef struct packed {
        data_word_t data;
        keep_t      keep;
        logic       last;
        logic       user;
    } beat_t;

    logic                 clk;
    logic                 rst;
    logic                 rx_hdr_valid;
    logic                 rx_hdr_ready;
    ip_addr_t             rx_src_ip;
    udp_port_t            rx_src_port;
    udp_port_t            rx_dest_port;
    udp_len_t             rx_udp_length;
    data_word_t           rx_data;
    keep_t                rx_keep;
    logic                 rx_valid;
    logic                 rx_ready;
    logic                 rx_last;
    logic                 rx_user;
    logic                 tx_hdr_valid;
    logic                 tx_hdr_ready;
    ip_addr_t             tx_dest_ip;
    udp_port_t            tx_src_port;
    udp_port_t            tx_dest_port;
    udp_len_t             tx_udp_length;
    data_word_t           tx_data;
    keep_t                tx_keep;
    logic                 tx_valid;
    logic                 tx_ready;
    logic                 tx_last;
    logic                 tx_user;
    logic [LED_WIDTH-1:0] led;

    hdr_t                 hdr_exp[$];
    hdr_t                 hdr_got[$];
    beat_t                beat_exp[$];
    beat_t                beat_got[$];
    logic [LED_WIDTH-1:0] led_exp;
    logic                 bp_en;
    int                   checks;
    int                   errors;
    int                   timeouts;

    udp_echo_top dut_i (.*);

    bind udp_echo_top udp_echo_chk chk_i (
        .clk          (clk),
        .rst          (rst),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .tx_keep      (tx_keep),
        .tx_last      (tx_last),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_src_port  (tx_src_port)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Random stalls on both reply channels while bp_en is set
    always @(negedge clk) begin
        tx_ready     = bp_en ? 1'($urandom % 2) : 1'b1;
        tx_hdr_ready = bp_en ? 1'($urandom % 2) : 1'b1;
    end

    // Reply side monitor samples once per cycle just before the rising edge
    always @(negedge clk) begin
        #1;
        if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_got.push_back({tx_dest_ip, tx_src_port, tx_dest_port, tx_udp_length});
        end
        if (tx_valid && tx_ready) begin
            beat_got.push_back({tx_data, tx_keep, tx_last, tx_user});
        end
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        led_exp = '0;
        #1;
        check_value("reset tx_valid", 64'(tx_valid), 64'd0);
        check_value("reset tx_hdr_valid", 64'(tx_hdr_valid), 64'd0);
        check_value("reset led", 64'(led), 64'd0);
        @(negedge clk);
    endtask

    // Starts and ends on a falling edge so frames can follow back to back
    task automatic send_frame(input ip_addr_t ip, input udp_port_t sport, input udp_port_t dport,
                              input int nbeats);
        beat_t    beats[$];
        beat_t    b;
        hdr_t     h;
        udp_len_t len;
        int       wait_cnt;
        len = 16'd8;
        for (int i = 0; i < nbeats; i++) begin
            b.data = {$urandom, $urandom};
            b.last = (i == nbeats - 1);
            b.keep = b.last ? (8'hff >> ($urandom % 8)) : 8'hff;
            b.user = 1'($urandom % 2);
            len = len + udp_len_t'($countones(b.keep));
            beats.push_back(b);
        end
        // Reply addresses the sender and swaps the ports
        if (dport == ECHO_PORT) begin
            h.dest_ip    = ip;
            h.src_port   = ECHO_PORT;
            h.dest_port  = sport;
            h.udp_length = len;
            hdr_exp.push_back(h);
            foreach (beats[i]) beat_exp.push_back(beats[i]);
            led_exp = beats[0].data[LED_WIDTH-1:0];
        end
        rx_hdr_valid  = 1'b1;
        rx_src_ip     = ip;
        rx_src_port   = sport;
        rx_dest_port  = dport;
        rx_udp_length = len;
        wait_cnt = 0;
        #1;
        while (!rx_hdr_ready && wait_cnt < LIMIT) begin
            @(negedge clk);
            #1;
            wait_cnt++;
        end
        if (!rx_hdr_ready) report_timeout("rx_hdr_ready");
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        foreach (beats[i]) begin
            rx_valid = 1'b1;
            rx_data  = beats[i].data;
            rx_keep  = beats[i].keep;
            rx_last  = beats[i].last;
            rx_user  = beats[i].user;
            wait_cnt = 0;
            #1;
            while (!rx_ready && wait_cnt < LIMIT) begin
                @(negedge clk);
                #1;
                wait_cnt++;
            end
            if (!rx_ready) report_timeout("rx_ready");
            @(negedge clk);
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic wait_replies();
        int wait_cnt;
        wait_cnt = 0;
        while ((beat_got.size() < beat_exp.size() || hdr_got.size() < hdr_exp.size())
               && wait_cnt < LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (beat_got.size() < beat_exp.size() || hdr_got.size() < hdr_exp.size()) begin
            report_timeout("tx replies");
        end
        @(negedge clk);
    endtask

    task automatic compare_results(input string test);
        hdr_t  hg;
        hdr_t  he;
        beat_t bg;
        beat_t be;
        // Quiet window catches stray replies
        repeat (QUIET) @(negedge clk);
        check_value({test, " tx_hdr_valid count"}, 64'(hdr_got.size()), 64'(hdr_exp.size()));
        check_value({test, " tx_valid count"}, 64'(beat_got.size()), 64'(beat_exp.size()));
        while (hdr_got.size() > 0 && hdr_exp.size() > 0) begin
            hg = hdr_got.pop_front();
            he = hdr_exp.pop_front();
            check_value({test, " tx_dest_ip"}, 64'(hg.dest_ip), 64'(he.dest_ip));
            check_value({test, " tx_src_port"}, 64'(hg.src_port), 64'(he.src_port));
            check_value({test, " tx_dest_port"}, 64'(hg.dest_port), 64'(he.dest_port));
            check_value({test, " tx_udp_length"}, 64'(hg.udp_length), 64'(he.udp_length));
        end
        while (beat_got.size() > 0 && beat_exp.size() > 0) begin
            bg = beat_got.pop_front();
            be = beat_exp.pop_front();
            check_value({test, " tx_data"}, bg.data, be.data);
            check_value({test, " tx_keep"}, 64'(bg.keep), 64'(be.keep));
            check_value({test, " tx_last"}, 64'(bg.last), 64'(be.last));
            check_value({test, " tx_user"}, 64'(bg.user), 64'(be.user));
        end
        check_value({test, " led"}, 64'(led), 64'(led_exp));
        hdr_got.delete();
        hdr_exp.delete();
        beat_got.delete();
        beat_exp.delete();
    endtask

    task automatic test_echo();
        send_frame(32'hc0a8_0105, 16'd5000, ECHO_PORT, 5);
        send_frame(32'h0a00_0002, 16'd40000, ECHO_PORT, 1);
        wait_replies();
        compare_results("echo");
    endtask

    task automatic test_drop();
        send_frame(32'hc0a8_0107, 16'd5001, 16'd1235, 4);
        send_frame(32'hc0a8_0108, 16'd5002, 16'd53, 1);
        wait_replies();
        compare_results("drop");
    endtask

    task automatic test_backpressure();
        bp_en = 1'b1;
        send_frame(ip_addr_t'($urandom), 16'd6000, ECHO_PORT, 40);
        send_frame(ip_addr_t'($urandom), 16'd6001, ECHO_PORT, 33);
        wait_replies();
        bp_en = 1'b0;
        compare_results("backpressure");
    endtask

    task automatic test_led();
        for (int i = 0; i < 4; i++) begin
            send_frame(ip_addr_t'($urandom), 16'(4000 + i),
                       (i % 2 == 0) ? ECHO_PORT : 16'd9, 1 + i);
            wait_replies();
            compare_results("led");
        end
    endtask

    task automatic test_mixed();
        for (int i = 0; i < 6; i++) begin
            send_frame(ip_addr_t'($urandom), 16'(7000 + i),
                       (i % 2 == 1) ? ECHO_PORT : 16'(80 + i),
                       1 + int'($urandom % 6));
        end
        wait_replies();
        compare_results("mixed");
    endtask

    initial begin
        void'($urandom(SEED));
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        bp_en         = 1'b0;
        rst           = 1'b1;
        rx_hdr_valid  = 1'b0;
        rx_src_ip     = '0;
        rx_src_port   = '0;
        rx_dest_port  = '0;
        rx_udp_length = '0;
        rx_data       = '0;
        rx_keep       = '0;
        rx_valid      = 1'b0;
        rx_last       = 1'b0;
        rx_user       = 1'b0;
        tx_hdr_ready  = 1'b1;
        tx_ready      = 1'b1;
        apply_reset();
        test_echo();
        test_drop();
        test_backpressure();
        test_led();
        test_mixed();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* list.f */
source/udp_field_pkg.sv
source/echo_cfg_pkg.sv
source/axis_payload_if.sv
source/echo_port_filter.sv
source/payload_fifo.sv
source/led_capture.sv
source/udp_echo_top.sv
dv/udp_echo_chk.sv
dv/udp_echo_tb.sv

/* run.sh */
#!/bin/sh
# Builds the UDP echo testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module udp_echo_tb \
    -f list.f -o udp_echo_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/udp_echo_sim > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "Run OK" || { echo "Run FAILED"; exit 1; }
